//--- net_pkg.sv
// Network configuration and memory command package
// Shared widths, opcodes, reset defaults and the configuration data word

package net_pkg;

    // Register stages between the user region and the stack
    localparam int N_REG_NET_S0 = 2;

    localparam int IP_ADDR_BITS  = 32;
    localparam int MAC_ADDR_BITS = 48;
    localparam int MEM_ADDR_BITS = 64;
    localparam int MEM_LEN_BITS  = 28;
    localparam int CFG_OP_BITS   = 2;

    // Configuration stream opcodes
    localparam logic [CFG_OP_BITS-1:0] CFG_OP_SET_IP  = 2'd0;
    localparam logic [CFG_OP_BITS-1:0] CFG_OP_SET_MAC = 2'd1;
    localparam logic [CFG_OP_BITS-1:0] CFG_OP_ARP_LUP = 2'd2;

    // Addresses after reset
    localparam logic [IP_ADDR_BITS-1:0]  DEFAULT_IP_ADDR  = 32'h0A01_D497;
    localparam logic [MAC_ADDR_BITS-1:0] DEFAULT_MAC_ADDR = 48'h0002_B3C4_D5E6;

    // Configuration payload, read as a MAC address or as a padded IP address
    // (the IP view also carries ARP lookup targets)
    typedef union packed {
        logic [MAC_ADDR_BITS-1:0] mac;
        struct packed {
            logic [MAC_ADDR_BITS-IP_ADDR_BITS-1:0] pad;
            logic [IP_ADDR_BITS-1:0]               ip;
        } ip_view;
    } net_cfg_data_u;

endpackage

//--- net_cfg_arbiter.sv
// Configuration request arbiter
// Merges set IP, set MAC and ARP lookup requests into one opcode-tagged
// stream, fixed priority MAC > IP > ARP, behind a single output register

module net_cfg_arbiter import net_pkg::*; (
    input  logic                     aclk,
    input  logic                     aresetn,

    input  logic                     set_ip_valid,
    input  logic [IP_ADDR_BITS-1:0]  set_ip_addr,
    output logic                     set_ip_ready,

    input  logic                     set_mac_valid,
    input  logic [MAC_ADDR_BITS-1:0] set_mac_addr,
    output logic                     set_mac_ready,

    input  logic                     arp_lup_valid,
    input  logic [IP_ADDR_BITS-1:0]  arp_lup_addr,
    output logic                     arp_lup_ready,

    output logic                     cfg_valid,
    output logic [CFG_OP_BITS-1:0]   cfg_op,
    output net_cfg_data_u            cfg_data,
    input  logic                     cfg_ready
);

    logic                   load_en;
    logic [CFG_OP_BITS-1:0] nxt_op;
    net_cfg_data_u          nxt_data;

    // Output register empty or draining this cycle
    assign load_en = !cfg_valid || cfg_ready;

    // Lower priority channels only see ready when nobody above is pending
    assign set_mac_ready = load_en;
    assign set_ip_ready  = load_en && !set_mac_valid;
    assign arp_lup_ready = load_en && !set_mac_valid && !set_ip_valid;

    always_comb begin
        nxt_op              = CFG_OP_ARP_LUP;
        nxt_data            = '0;
        nxt_data.ip_view.ip = arp_lup_addr;
        if (set_mac_valid) begin
            nxt_op       = CFG_OP_SET_MAC;
            nxt_data.mac = set_mac_addr;
        end else if (set_ip_valid) begin
            nxt_op              = CFG_OP_SET_IP;
            nxt_data.ip_view.ip = set_ip_addr;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cfg_valid <= 1'b0;
        end else if (load_en) begin
            cfg_valid <= set_mac_valid || set_ip_valid || arp_lup_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (load_en) begin
            cfg_op   <= nxt_op;
            cfg_data <= nxt_data;
        end
    end

endmodule

//--- net_slice_array.sv
// Register slice chain for the configuration stream
// N_REG_NET_S0 valid/ready stages; an empty stage still accepts, so bubbles close up

module net_slice_array import net_pkg::*; (
    input  logic                   aclk,
    input  logic                   aresetn,

    input  logic                   s_valid,
    input  logic [CFG_OP_BITS-1:0] s_op,
    input  net_cfg_data_u          s_data,
    output logic                   s_ready,

    output logic                   m_valid,
    output logic [CFG_OP_BITS-1:0] m_op,
    output net_cfg_data_u          m_data,
    input  logic                   m_ready
);

    logic                   stg_valid [N_REG_NET_S0];
    logic [CFG_OP_BITS-1:0] stg_op    [N_REG_NET_S0];
    net_cfg_data_u          stg_data  [N_REG_NET_S0];
    logic                   stg_ready [N_REG_NET_S0];

    for (genvar i = 0; i < N_REG_NET_S0; i++) begin : g_stage
        logic                   in_valid;
        logic [CFG_OP_BITS-1:0] in_op;
        net_cfg_data_u          in_data;
        logic                   out_ready;

        if (i == 0) begin : g_head
            assign in_valid = s_valid;
            assign in_op    = s_op;
            assign in_data  = s_data;
        end else begin : g_link
            assign in_valid = stg_valid[i-1];
            assign in_op    = stg_op[i-1];
            assign in_data  = stg_data[i-1];
        end

        if (i == N_REG_NET_S0 - 1) begin : g_tail
            assign out_ready = m_ready;
        end else begin : g_next
            assign out_ready = stg_ready[i+1];
        end

        assign stg_ready[i] = !stg_valid[i] || out_ready;

        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                stg_valid[i] <= 1'b0;
            end else if (stg_ready[i]) begin
                stg_valid[i] <= in_valid;
            end
        end

        always_ff @(posedge aclk) begin
            if (stg_ready[i] && in_valid) begin
                stg_op[i]   <= in_op;
                stg_data[i] <= in_data;
            end
        end
    end

    assign s_ready = stg_ready[0];
    assign m_valid = stg_valid[N_REG_NET_S0-1];
    assign m_op    = stg_op[N_REG_NET_S0-1];
    assign m_data  = stg_data[N_REG_NET_S0-1];

endmodule

//--- net_cfg_regs.sv
// Network configuration registers
// Holds the current IP and MAC addresses and queues ARP lookups for the stack

module net_cfg_regs import net_pkg::*; (
    input  logic                     aclk,
    input  logic                     aresetn,

    input  logic                     cfg_valid,
    input  logic [CFG_OP_BITS-1:0]   cfg_op,
    input  net_cfg_data_u            cfg_data,
    output logic                     cfg_ready,

    output logic [IP_ADDR_BITS-1:0]  ip_addr,
    output logic [MAC_ADDR_BITS-1:0] mac_addr,

    output logic                     arp_req_valid,
    output logic [IP_ADDR_BITS-1:0]  arp_req_addr,
    input  logic                     arp_req_ready
);

    logic cfg_take;
    logic is_arp;
    logic arp_load;

    assign is_arp = (cfg_op == CFG_OP_ARP_LUP);

    // Address updates never stall, only ARP waits for a free output slot
    assign cfg_ready = !is_arp || !arp_req_valid || arp_req_ready;
    assign cfg_take  = cfg_valid && cfg_ready;
    assign arp_load  = cfg_take && is_arp;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ip_addr  <= DEFAULT_IP_ADDR;
            mac_addr <= DEFAULT_MAC_ADDR;
        end else if (cfg_take) begin
            case (cfg_op)
                CFG_OP_SET_IP:  ip_addr  <= cfg_data.ip_view.ip;
                CFG_OP_SET_MAC: mac_addr <= cfg_data.mac;
                default: ;
            endcase
        end
    end

    // One-entry ARP request register
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arp_req_valid <= 1'b0;
        end else if (arp_load) begin
            arp_req_valid <= 1'b1;
        end else if (arp_req_ready) begin
            arp_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (arp_load) begin
            arp_req_addr <= cfg_data.ip_view.ip;
        end
    end

endmodule

//--- net_mem_offset.sv
// Memory command offset adder
// Pipelines the DDR base offset and adds it to each stack memory command address

module net_mem_offset import net_pkg::*; (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic [MEM_ADDR_BITS-1:0] ddr_offset,

    input  logic                     mem_cmd_valid,
    input  logic [MEM_ADDR_BITS-1:0] mem_cmd_addr,
    input  logic [MEM_LEN_BITS-1:0]  mem_cmd_len,
    output logic                     mem_cmd_ready,

    output logic                     mem_out_valid,
    output logic [MEM_ADDR_BITS-1:0] mem_out_addr,
    output logic [MEM_LEN_BITS-1:0]  mem_out_len,
    input  logic                     mem_out_ready
);

    logic [MEM_ADDR_BITS-1:0] offset_q [N_REG_NET_S0];
    logic                     cmd_take;

    // Offset delay line, same depth as the user-side slicing
    always_ff @(posedge aclk) begin
        offset_q[0] <= ddr_offset;
        for (int i = 1; i < N_REG_NET_S0; i++) begin
            offset_q[i] <= offset_q[i-1];
        end
    end

    assign mem_cmd_ready = !mem_out_valid || mem_out_ready;
    assign cmd_take      = mem_cmd_valid && mem_cmd_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            mem_out_valid <= 1'b0;
        end else if (mem_cmd_ready) begin
            mem_out_valid <= mem_cmd_valid;
        end
    end

    // Address wraps modulo 2^64
    always_ff @(posedge aclk) begin
        if (cmd_take) begin
            mem_out_addr <= mem_cmd_addr + offset_q[N_REG_NET_S0-1];
            mem_out_len  <= mem_cmd_len;
        end
    end

endmodule

//--- net_top.sv
// Network top level
// User configuration path through arbiter, slice chain and config registers,
// plus the memory command path with the DDR offset applied

module net_top import net_pkg::*; (
    input  logic                     aclk,
    input  logic                     aresetn,

    // User configuration
    input  logic                     set_ip_valid,
    input  logic [IP_ADDR_BITS-1:0]  set_ip_addr,
    output logic                     set_ip_ready,
    input  logic                     set_mac_valid,
    input  logic [MAC_ADDR_BITS-1:0] set_mac_addr,
    output logic                     set_mac_ready,
    input  logic                     arp_lup_valid,
    input  logic [IP_ADDR_BITS-1:0]  arp_lup_addr,
    output logic                     arp_lup_ready,

    // Stack side
    output logic                     arp_req_valid,
    output logic [IP_ADDR_BITS-1:0]  arp_req_addr,
    input  logic                     arp_req_ready,
    output logic [IP_ADDR_BITS-1:0]  ip_addr,
    output logic [MAC_ADDR_BITS-1:0] mac_addr,

    // Memory commands
    input  logic [MEM_ADDR_BITS-1:0] ddr_offset,
    input  logic                     mem_cmd_valid,
    input  logic [MEM_ADDR_BITS-1:0] mem_cmd_addr,
    input  logic [MEM_LEN_BITS-1:0]  mem_cmd_len,
    output logic                     mem_cmd_ready,
    output logic                     mem_out_valid,
    output logic [MEM_ADDR_BITS-1:0] mem_out_addr,
    output logic [MEM_LEN_BITS-1:0]  mem_out_len,
    input  logic                     mem_out_ready
);

    // Arbiter to slice chain
    logic                   arb_valid;
    logic                   arb_ready;
    logic [CFG_OP_BITS-1:0] arb_op;
    net_cfg_data_u          arb_data;

    // Slice chain to config registers
    logic                   cfg_valid;
    logic                   cfg_ready;
    logic [CFG_OP_BITS-1:0] cfg_op;
    net_cfg_data_u          cfg_data;

    net_cfg_arbiter u_arbiter (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .set_ip_valid  (set_ip_valid),
        .set_ip_addr   (set_ip_addr),
        .set_ip_ready  (set_ip_ready),
        .set_mac_valid (set_mac_valid),
        .set_mac_addr  (set_mac_addr),
        .set_mac_ready (set_mac_ready),
        .arp_lup_valid (arp_lup_valid),
        .arp_lup_addr  (arp_lup_addr),
        .arp_lup_ready (arp_lup_ready),
        .cfg_valid     (arb_valid),
        .cfg_op        (arb_op),
        .cfg_data      (arb_data),
        .cfg_ready     (arb_ready)
    );

    net_slice_array u_slice_array (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (arb_valid),
        .s_op    (arb_op),
        .s_data  (arb_data),
        .s_ready (arb_ready),
        .m_valid (cfg_valid),
        .m_op    (cfg_op),
        .m_data  (cfg_data),
        .m_ready (cfg_ready)
    );

    net_cfg_regs u_cfg_regs (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cfg_valid     (cfg_valid),
        .cfg_op        (cfg_op),
        .cfg_data      (cfg_data),
        .cfg_ready     (cfg_ready),
        .ip_addr       (ip_addr),
        .mac_addr      (mac_addr),
        .arp_req_valid (arp_req_valid),
        .arp_req_addr  (arp_req_addr),
        .arp_req_ready (arp_req_ready)
    );

    net_mem_offset u_mem_offset (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ddr_offset    (ddr_offset),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_addr  (mem_cmd_addr),
        .mem_cmd_len   (mem_cmd_len),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_out_valid (mem_out_valid),
        .mem_out_addr  (mem_out_addr),
        .mem_out_len   (mem_out_len),
        .mem_out_ready (mem_out_ready)
    );

endmodule

//--- net_top_sva.sv
// Handshake assertions for the network top level
// Bound into net_top to watch reset values, output stability and memory output causality

module net_top_sva import net_pkg::*; (
    input logic                     aclk,
    input logic                     aresetn,
    input logic                     arp_req_valid,
    input logic                     arp_req_ready,
    input logic [IP_ADDR_BITS-1:0]  arp_req_addr,
    input logic                     mem_cmd_valid,
    input logic                     mem_cmd_ready,
    input logic                     mem_out_valid,
    input logic                     mem_out_ready,
    input logic [MEM_ADDR_BITS-1:0] mem_out_addr,
    input logic [MEM_LEN_BITS-1:0]  mem_out_len
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    a_reset_valid: assert property (@(posedge aclk)
        !aresetn |=> !arp_req_valid && !mem_out_valid)
        else begin
            $error("output valid still high after a reset cycle");
            fail_count++;
        end

    a_arp_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arp_req_valid && !arp_req_ready |=> arp_req_valid && $stable(arp_req_addr))
        else begin
            $error("ARP request dropped or changed before it was taken");
            fail_count++;
        end

    a_mem_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_out_valid && !mem_out_ready |=>
            mem_out_valid && $stable(mem_out_addr) && $stable(mem_out_len))
        else begin
            $error("memory output dropped or changed before it was taken");
            fail_count++;
        end

    // Output register loads one cycle after a command is taken
    a_mem_cause: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(mem_out_valid) |-> $past(mem_cmd_valid && mem_cmd_ready))
        else begin
            $error("memory output rose without a command acceptance");
            fail_count++;
        end

endmodule

bind net_top net_top_sva u_sva (.*);

//--- tb_net_top.sv
// Testbench for the network top level
// Table-driven config and memory requests with random back-pressure on outputs

module tb_net_top import net_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 4;
    localparam int          MAX_WAIT   = 200;
    localparam logic [63:0] OFFSET     = 64'hFFFF_0000_0000_1000;

    // Stimulus kinds
    localparam logic [2:0] K_IP  = 3'd0;
    localparam logic [2:0] K_MAC = 3'd1;
    localparam logic [2:0] K_ARP = 3'd2;
    localparam logic [2:0] K_MEM = 3'd3;
    localparam logic [2:0] K_ALL = 3'd4;

    typedef struct packed {
        logic [2:0]  kind;
        logic [63:0] value;
        logic [63:0] result;
    } entry_t;

    localparam int N_ENTRIES = 14;

    // Memory results are address plus OFFSET, wrapped to 64 bits
    entry_t stim [N_ENTRIES] = '{
        '{K_IP,  64'h0000_0000_C0A8_0001, 64'h0000_0000_C0A8_0001},
        '{K_MAC, 64'h0000_1A2B_3C4D_5E6F, 64'h0000_1A2B_3C4D_5E6F},
        '{K_ARP, 64'h0000_0000_C0A8_0010, 64'h0000_0000_C0A8_0010},
        '{K_ARP, 64'h0000_0000_C0A8_0011, 64'h0000_0000_C0A8_0011},
        '{K_ARP, 64'h0000_0000_C0A8_0012, 64'h0000_0000_C0A8_0012},
        '{K_ARP, 64'h0000_0000_C0A8_0013, 64'h0000_0000_C0A8_0013},
        '{K_ARP, 64'h0000_0000_C0A8_0014, 64'h0000_0000_C0A8_0014},
        '{K_IP,  64'h0000_0000_AC10_0102, 64'h0000_0000_AC10_0102},
        '{K_MEM, 64'h0000_2000_0000_0F00, 64'hFFFF_2000_0000_1F00},
        '{K_MEM, 64'h0001_0000_0000_0000, 64'h0000_0000_0000_1000},
        '{K_MEM, 64'h0000_0000_0000_0040, 64'hFFFF_0000_0000_1040},
        '{K_ALL, 64'h0000_0A0B_0C0D_0E0F, 64'h0000_0000_F3F2_F1F0},
        '{K_MAC, 64'h0000_DEAD_BEEF_0001, 64'h0000_DEAD_BEEF_0001},
        '{K_MEM, 64'hFFFF_FFFF_FFFF_F000, 64'hFFFF_0000_0000_0000}
    };

    logic aclk, aresetn;
    logic set_ip_valid, set_ip_ready, set_mac_valid, set_mac_ready;
    logic arp_lup_valid, arp_lup_ready, arp_req_valid, arp_req_ready;
    logic mem_cmd_valid, mem_cmd_ready, mem_out_valid, mem_out_ready;
    logic [IP_ADDR_BITS-1:0]  set_ip_addr, arp_lup_addr, arp_req_addr, ip_addr, last_ip;
    logic [MAC_ADDR_BITS-1:0] set_mac_addr, mac_addr, last_mac;
    logic [MEM_ADDR_BITS-1:0] ddr_offset, mem_cmd_addr, mem_out_addr;
    logic [MEM_LEN_BITS-1:0]  mem_cmd_len, mem_out_len;

    // Expected outputs in order of issue
    logic [IP_ADDR_BITS-1:0]  arp_q [$];
    logic [MEM_ADDR_BITS-1:0] mem_addr_q [$];
    logic [MEM_LEN_BITS-1:0]  mem_len_q [$];

    net_top u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(N_ENTRIES * MAX_WAIT * CLK_PERIOD);
        $display("Timeout: the run did not complete in the allotted time");
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got == want) else begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            stop_with_failure();
        end
    endtask

    // Drive point is 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge aclk);
        #1;
    endtask

    // Bit 0 of sel is set IP, 1 set MAC, 2 ARP lookup and 3 memory command
    task automatic push_request(input logic [3:0] sel, input logic [63:0] value,
                                input logic [63:0] aux, input logic [MEM_LEN_BITS-1:0] len);
        int         waited;
        logic [3:0] go;
        waited = 0;
        {mem_cmd_valid, arp_lup_valid, set_mac_valid, set_ip_valid} = sel;
        set_ip_addr  = value[IP_ADDR_BITS-1:0];
        set_mac_addr = value[MAC_ADDR_BITS-1:0];
        arp_lup_addr = aux[IP_ADDR_BITS-1:0];
        mem_cmd_addr = value;
        mem_cmd_len  = len;
        if (sel[2])
            arp_q.push_back(aux[IP_ADDR_BITS-1:0]);
        if (sel[3]) begin
            mem_addr_q.push_back(aux);
            mem_len_q.push_back(len);
        end
        while ({mem_cmd_valid, arp_lup_valid, set_mac_valid, set_ip_valid} != 4'b0) begin
            @(negedge aclk);
            go = {mem_cmd_valid && mem_cmd_ready, arp_lup_valid && arp_lup_ready,
                  set_mac_valid && set_mac_ready, set_ip_valid && set_ip_ready};
            step_cycle();
            {mem_cmd_valid, arp_lup_valid, set_mac_valid, set_ip_valid} =
                {mem_cmd_valid, arp_lup_valid, set_mac_valid, set_ip_valid} & ~go;
            waited++;
            assert (waited < MAX_WAIT) else begin
                $display("Timeout: a request was never accepted by the DUT");
                stop_with_failure();
            end
        end
    endtask

    // Status may lag behind queued ARP items, so poll with a bound
    task automatic wait_status(input logic is_mac, input logic [63:0] want);
        logic [63:0] seen;
        int          waited;
        waited = 0;
        seen   = is_mac ? 64'(mac_addr) : 64'(ip_addr);
        while (seen != want && waited < MAX_WAIT) begin
            @(negedge aclk);
            seen = is_mac ? 64'(mac_addr) : 64'(ip_addr);
            waited++;
        end
        check_value(is_mac ? "mac_addr" : "ip_addr", seen, want);
        step_cycle();
    endtask

    // ARP consumer on the stack side
    initial begin
        logic [IP_ADDR_BITS-1:0] want;
        arp_req_ready = 1'b0;
        forever begin
            step_cycle();
            arp_req_ready = ($urandom % 4) != 0;
            @(negedge aclk);
            if (arp_req_valid && arp_req_ready) begin
                assert (arp_q.size() > 0) else begin
                    $display("An ARP request came out with no lookup outstanding");
                    stop_with_failure();
                end
                want = arp_q.pop_front();
                check_value("arp_req_addr", 64'(arp_req_addr), 64'(want));
            end
        end
    end

    // Memory command consumer
    initial begin
        mem_out_ready = 1'b0;
        forever begin
            step_cycle();
            mem_out_ready = ($urandom % 3) != 0;
            @(negedge aclk);
            if (mem_out_valid && mem_out_ready) begin
                assert (mem_addr_q.size() > 0) else begin
                    $display("A memory command came out with none outstanding");
                    stop_with_failure();
                end
                check_value("mem_out_addr", mem_out_addr, mem_addr_q.pop_front());
                check_value("mem_out_len", 64'(mem_out_len), 64'(mem_len_q.pop_front()));
            end
        end
    end

    initial forever begin
        @(negedge aclk);
        assert (u_dut.u_sva.fail_count == 0) else begin
            $display("A bound handshake assertion failed");
            stop_with_failure();
        end
    end

    initial begin
        int waited;
        int gap;
        void'($urandom(32'h944bfddc));
        aresetn    = 1'b0;
        ddr_offset = OFFSET;
        {set_ip_valid, set_mac_valid, arp_lup_valid, mem_cmd_valid} = '0;
        {set_ip_addr, set_mac_addr, arp_lup_addr, mem_cmd_addr, mem_cmd_len} = '0;
        last_ip  = DEFAULT_IP_ADDR;
        last_mac = DEFAULT_MAC_ADDR;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        check_value("ip_addr", 64'(ip_addr), 64'(DEFAULT_IP_ADDR));
        check_value("mac_addr", 64'(mac_addr), 64'(DEFAULT_MAC_ADDR));
        check_value("arp_req_valid", 64'(arp_req_valid), 64'h0);
        check_value("mem_out_valid", 64'(mem_out_valid), 64'h0);
        // Let the offset delay line fill
        repeat (N_REG_NET_S0 + 1) step_cycle();

        for (int i = 0; i < N_ENTRIES; i++) begin
            case (stim[i].kind)
                K_IP: begin
                    push_request(4'b0001, stim[i].value, '0, '0);
                    last_ip = stim[i].result[IP_ADDR_BITS-1:0];
                    wait_status(1'b0, stim[i].result);
                end
                K_MAC: begin
                    push_request(4'b0010, stim[i].value, '0, '0);
                    last_mac = stim[i].result[MAC_ADDR_BITS-1:0];
                    wait_status(1'b1, stim[i].result);
                end
                K_ARP: push_request(4'b0100, '0, stim[i].value, '0);
                K_MEM: push_request(4'b1000, stim[i].value, stim[i].result,
                                    MEM_LEN_BITS'(i * 1000 + 64));
                default: begin
                    // IP, MAC and ARP all raised in the same cycle
                    push_request(4'b0111, stim[i].value, stim[i].result, '0);
                    last_ip  = stim[i].value[IP_ADDR_BITS-1:0];
                    last_mac = stim[i].value[MAC_ADDR_BITS-1:0];
                    wait_status(1'b0, 64'(last_ip));
                    wait_status(1'b1, 64'(last_mac));
                end
            endcase
            gap = $urandom % 3;
            repeat (gap) step_cycle();
        end

        waited = 0;
        while ((arp_q.size() != 0 || mem_addr_q.size() != 0) && waited < MAX_WAIT) begin
            step_cycle();
            waited++;
        end
        check_value("ip_addr", 64'(ip_addr), 64'(last_ip));
        check_value("mac_addr", 64'(mac_addr), 64'(last_mac));
        if (arp_q.size() == 0 && mem_addr_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Timeout: ARP requests or memory commands never came out");
            stop_with_failure();
        end
    end

endmodule

//--- tb.f
net_pkg.sv
net_cfg_arbiter.sv
net_slice_array.sv
net_cfg_regs.sv
net_mem_offset.sv
net_top.sv
net_top_sva.sv
tb_net_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_net_top
FILELIST  := tb.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)
